/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_serial_core
FILELIST = serial_core.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* serial_core.f */
source/rv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/instr_decode.sv
source/core_fsm.sv
source/bit_counter.sv
source/imm_operand.sv
source/serial_alu.sv
source/reg_file.sv
source/serial_core.sv
sim/tb_serial_core.sv

/* sim/tb_serial_core.sv */
`timescale 1ns/1ps

module tb_serial_core
   import rv_isa_pkg::*;
();

   // Random ops per test
   localparam int IMM_OPS = 16;
   localparam int REG_OPS = 20;
   // Upper bound on issued instructions, sets the watchdog
   localparam int NUM_INSTR = 1 + 8 + IMM_OPS + REG_OPS + 46 + 8 + 4;
   localparam int WATCHDOG_CYCLES = NUM_INSTR * 40 + 16 + 400;
   localparam int RETIRE_LATENCY = 34;

   logic      clk;
   logic      i_rst_n;
   logic      i_ibus_ack;
   instr_t    i_ibus_rdt;
   logic      o_ibus_cyc;
   logic      o_retire;
   logic      o_rd_wen;
   reg_addr_t o_rd_addr;
   word_t     o_rd_data;

   // Expected register contents, x0 never written
   word_t shadow [32];
   int    cyc = 0;
   int    errors = 0;
   int    checks = 0;
   int    tests = 0;

   serial_core i_dut (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_retire   (o_retire),
      .o_rd_wen   (o_rd_wen),
      .o_rd_addr  (o_rd_addr),
      .o_rd_data  (o_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Cycle number, used for the latency check
   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (act !== exp) begin
         $display("** Error at %t: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
      checks++;
      if (act !== exp) begin
         $display("** Error at %t: %s expected %0d, got %0d", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         $display("** Error at %t: %s expected %b, got %b", $time, name, exp, act);
         errors++;
      end
   endtask

   // Instruction encoders
   function automatic instr_t r_type(input logic sub, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input funct3_t f3,
                                     input reg_addr_t rd);
      r_type = {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OPC_OP, 2'b11};
   endfunction

   function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input funct3_t f3, input reg_addr_t rd);
      i_type = {imm, rs1, f3, rd, OPC_OP_IMM, 2'b11};
   endfunction

   // SW, opcode 0100011
   function automatic instr_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
      s_type = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   // Writes only for OP and OP-IMM without shifts, never to x0
   function automatic logic model_writes(input instr_t instr);
      logic op_ok;
      logic f3_ok;
      op_ok = (instr[6:2] == OPC_OP) || (instr[6:2] == OPC_OP_IMM);
      f3_ok = (instr[14:12] != F3_SLL) && (instr[14:12] != F3_SRL);
      model_writes = op_ok && f3_ok && (instr[11:7] != 5'd0);
   endfunction

   // RV32I result from the shadow registers
   function automatic word_t model_value(input instr_t instr);
      word_t a;
      word_t b;
      logic  is_imm;
      a      = shadow[instr[19:15]];
      is_imm = (instr[6:2] == OPC_OP_IMM);
      // I-immediate sign-extended from bit 31
      b      = is_imm ? {{20{instr[31]}}, instr[31:20]} : shadow[instr[24:20]];
      case (instr[14:12])
         F3_ADD:  model_value = (!is_imm && instr[30]) ? a - b : a + b;
         F3_SLT:  model_value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         F3_SLTU: model_value = (a < b) ? 32'd1 : 32'd0;
         F3_XOR:  model_value = a ^ b;
         F3_OR:   model_value = a | b;
         F3_AND:  model_value = a & b;
         default: model_value = '0;
      endcase
   endfunction

   // Offer one instruction after gap idle cycles and check its retire
   task automatic issue_instr(input instr_t instr, input int gap);
      logic  exp_wen;
      word_t exp_val;
      int    ack_cyc;
      int    waited;
      int    i;
      exp_wen = model_writes(instr);
      exp_val = model_value(instr);
      waited  = 0;
      @(negedge clk);
      while (!o_ibus_cyc && waited < 100) begin
         @(negedge clk);
         waited++;
      end
      if (!o_ibus_cyc) begin
         $display("Request missing: o_ibus_cyc stayed low for 100 cycles");
         errors++;
         return;
      end
      // Core must hold the request while the bus stalls
      for (i = 0; i < gap; i++) begin
         @(negedge clk);
         check_bit("o_ibus_cyc", 1'b1, o_ibus_cyc);
      end
      @(posedge clk);
      #2;
      i_ibus_ack = 1'b1;
      i_ibus_rdt = instr;
      ack_cyc    = cyc;
      @(posedge clk);
      #2;
      i_ibus_ack = 1'b0;
      @(negedge clk);
      // Request drops the cycle after the ack
      check_bit("o_ibus_cyc", 1'b0, o_ibus_cyc);
      waited = 0;
      while (!o_retire && waited < 100) begin
         @(negedge clk);
         waited++;
      end
      if (!o_retire) begin
         $display("Retire missing: no o_retire within 100 cycles of the ack");
         errors++;
         return;
      end
      if (cyc - ack_cyc != RETIRE_LATENCY) begin
         $display("Latency wrong: o_retire came %0d cycles after the ack, expected %0d",
                  cyc - ack_cyc, RETIRE_LATENCY);
         errors++;
      end
      // Next request opens in the retire cycle
      check_bit("o_ibus_cyc", 1'b1, o_ibus_cyc);
      check_bit("o_rd_wen", exp_wen, o_rd_wen);
      if (exp_wen) begin
         check_addr("o_rd_addr", instr[11:7], o_rd_addr);
         check_word("o_rd_data", exp_val, o_rd_data);
         shadow[instr[11:7]] = exp_val;
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      tests++;
      if (errors == err_start) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, errors - err_start);
      end
   endtask

   task automatic reset_and_request();
      int err_start;
      int i;
      err_start = errors;
      for (i = 0; i < 16; i++) begin
         @(posedge clk);
         #2;
         check_bit("o_ibus_cyc", 1'b0, o_ibus_cyc);
         check_bit("o_retire", 1'b0, o_retire);
      end
      i_rst_n = 1'b1;
      @(posedge clk);
      #2;
      check_bit("o_ibus_cyc", 1'b1, o_ibus_cyc);
      issue_instr(i_type(12'h123, 5'd0, F3_ADD, 5'd1), int'($urandom_range(10, 1)));
      report_test("reset_and_request", err_start);
   endtask

   task automatic imm_arith();
      funct3_t     ops [4] = '{F3_ADD, F3_XOR, F3_OR, F3_AND};
      logic [11:0] imm;
      int unsigned r;
      int          err_start;
      int          i;
      err_start = errors;
      // Seed x1 to x8 from x0
      for (i = 1; i <= 8; i++) begin
         r = $urandom;
         issue_instr(i_type(r[11:0], 5'd0, F3_ADD, reg_addr_t'(i)), 0);
      end
      for (i = 0; i < IMM_OPS; i++) begin
         r       = $urandom;
         imm     = r[11:0];
         // Alternate negative and positive
         imm[11] = i[0];
         issue_instr(i_type(imm, reg_addr_t'($urandom_range(8, 1)), ops[i % 4],
                            reg_addr_t'($urandom_range(8, 1))),
                     int'($urandom_range(3, 0)));
      end
      report_test("imm_arith", err_start);
   endtask

   task automatic reg_arith();
      funct3_t ops [5] = '{F3_ADD, F3_ADD, F3_XOR, F3_OR, F3_AND};
      int      sel;
      int      err_start;
      int      i;
      err_start = errors;
      for (i = 0; i < REG_OPS; i++) begin
         sel = int'($urandom_range(4, 0));
         // Slot 1 is SUB
         issue_instr(r_type(sel == 1, reg_addr_t'($urandom_range(8, 1)),
                            reg_addr_t'($urandom_range(8, 1)), ops[sel],
                            reg_addr_t'($urandom_range(8, 1))),
                     int'($urandom_range(3, 0)));
      end
      report_test("reg_arith", err_start);
   endtask

   task automatic compares();
      reg_addr_t   pa [6] = '{5'd10, 5'd10, 5'd11, 5'd12, 5'd13, 5'd12};
      reg_addr_t   pb [6] = '{5'd10, 5'd11, 5'd10, 5'd13, 5'd12, 5'd12};
      reg_addr_t   ia [5] = '{5'd12, 5'd13, 5'd12, 5'd10, 5'd11};
      logic [11:0] iv [5] = '{12'hfff, 12'hfff, 12'h001, 12'h7ff, 12'h800};
      int          err_start;
      int          i;
      err_start = errors;
      // Most negative value, -2048 doubled 20 times
      issue_instr(i_type(12'h800, 5'd0, F3_ADD, 5'd10), 0);
      for (i = 0; i < 20; i++) begin
         issue_instr(r_type(1'b0, 5'd10, 5'd10, F3_ADD, 5'd10), 0);
      end
      // Most positive, all ones and one
      issue_instr(i_type(12'hfff, 5'd10, F3_ADD, 5'd11), 0);
      issue_instr(i_type(12'hfff, 5'd0, F3_ADD, 5'd12), 0);
      issue_instr(i_type(12'h001, 5'd0, F3_ADD, 5'd13), 0);
      for (i = 0; i < 6; i++) begin
         issue_instr(r_type(1'b0, pb[i], pa[i], F3_SLT, 5'd14), 0);
         issue_instr(r_type(1'b0, pb[i], pa[i], F3_SLTU, 5'd15), 0);
      end
      for (i = 0; i < 5; i++) begin
         issue_instr(i_type(iv[i], ia[i], F3_SLT, 5'd14), 0);
         issue_instr(i_type(iv[i], ia[i], F3_SLTU, 5'd15), 0);
      end
      report_test("compares", err_start);
   endtask

   task automatic no_write_cases();
      int err_start;
      err_start = errors;
      issue_instr(i_type(12'h005, 5'd0, F3_ADD, 5'd0), 0);
      issue_instr(r_type(1'b0, 5'd2, 5'd1, F3_ADD, 5'd0), 0);
      // x0 as a source still reads zero
      issue_instr(r_type(1'b0, 5'd3, 5'd0, F3_ADD, 5'd5), 0);
      // Store with rd field 4, SLLI to x4, SRL to x6
      issue_instr(s_type(12'h004, 5'd2, 5'd1), 0);
      issue_instr(i_type(12'h003, 5'd1, F3_SLL, 5'd4), 0);
      issue_instr(r_type(1'b0, 5'd2, 5'd1, F3_SRL, 5'd6), 0);
      // Read back x4 and x6 unchanged
      issue_instr(r_type(1'b0, 5'd0, 5'd4, F3_ADD, 5'd7), 0);
      issue_instr(r_type(1'b0, 5'd0, 5'd6, F3_ADD, 5'd7), 0);
      report_test("no_write_cases", err_start);
   endtask

   task automatic retire_latency();
      int err_start;
      err_start = errors;
      // Back to back and stalled fetches
      issue_instr(r_type(1'b1, 5'd2, 5'd1, F3_ADD, 5'd3), 0);
      issue_instr(r_type(1'b0, 5'd3, 5'd3, F3_XOR, 5'd4), 10);
      issue_instr(i_type(12'h7ff, 5'd4, F3_ADD, 5'd5), 0);
      issue_instr(r_type(1'b0, 5'd5, 5'd1, F3_SLTU, 5'd6), 5);
      report_test("retire_latency", err_start);
   endtask

   initial begin
      int unsigned r;
      int          i;
      i_rst_n    = 1'b0;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      $timeformat(-9, 0, " ns", 0);
      r = $urandom(32'h448);
      for (i = 0; i < 32; i++) begin
         shadow[i] = '0;
      end
      reset_and_request();
      imm_arith();
      reg_arith();
      compares();
      no_write_cases();
      retire_latency();
      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

/* source/bit_counter.sv */
`timescale 1ns/1ps

module bit_counter
   import core_ctrl_pkg::*;
(
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_run,
   output logic o_last
);

   bit_cnt_t cnt;

   // Wraps from 31 back to 0 on its own
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cnt <= '0;
      end else if (i_run) begin
         cnt <= cnt + 1'b1;
      end
   end

   // Count sits at 0 outside a run
   assign o_last = (cnt == XLEN_LAST);

endmodule

/* source/core_ctrl_pkg.sv */
package core_ctrl_pkg;

   import rv_isa_pkg::*;

   // Core sequencing states
   typedef enum logic [1:0] {
      ST_FETCH,
      ST_LOAD,
      ST_RUN,
      ST_RETIRE
   } core_state_t;

   // Index of the bit currently in the serial datapath
   typedef logic [4:0] bit_cnt_t;

   // Last serial bit of a word
   localparam bit_cnt_t XLEN_LAST = 5'd31;

   // ALU control levels
   typedef struct packed {
      logic       sub;
      // funct3[1:0], 00 xor, 10 or, 11 and
      logic [1:0] bool_op;
      logic       cmp_sig;
      // One-hot, bit 0 add, bit 1 compare, bit 2 bool
      logic [2:0] rd_sel;
   } alu_ctrl_t;

   // Everything the decoder hands to the datapath
   typedef struct packed {
      reg_addr_t  rs1;
      reg_addr_t  rs2;
      reg_addr_t  rd;
      logic [11:0] imm;
      logic       op_b_imm;
      logic       rd_op;
      alu_ctrl_t  alu;
   } decode_t;

endpackage

/* source/core_fsm.sv */
`timescale 1ns/1ps

module core_fsm
   import core_ctrl_pkg::*;
(
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_ibus_ack,
   input  logic i_last,
   output logic o_ibus_cyc,
   output logic o_load,
   output logic o_run,
   output logic o_retire
);

   core_state_t state;
   core_state_t state_nxt;
   logic        take;

   // Ack counts only while a request is open
   assign take = o_ibus_cyc & i_ibus_ack;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_FETCH: begin
            if (take) begin
               state_nxt = ST_LOAD;
            end
         end
         ST_LOAD: begin
            state_nxt = ST_RUN;
         end
         ST_RUN: begin
            if (i_last) begin
               state_nxt = ST_RETIRE;
            end
         end
         // Next request already open during retire
         ST_RETIRE: begin
            state_nxt = take ? ST_LOAD : ST_FETCH;
         end
         default: begin
            state_nxt = ST_FETCH;
         end
      endcase
   end

   // Outputs registered from the next state, all low in reset
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state      <= ST_FETCH;
         o_ibus_cyc <= 1'b0;
         o_load     <= 1'b0;
         o_run      <= 1'b0;
         o_retire   <= 1'b0;
      end else begin
         state      <= state_nxt;
         o_ibus_cyc <= (state_nxt == ST_FETCH) | (state_nxt == ST_RETIRE);
         o_load     <= (state_nxt == ST_LOAD);
         o_run      <= (state_nxt == ST_RUN);
         o_retire   <= (state_nxt == ST_RETIRE);
      end
   end

endmodule

/* source/imm_operand.sv */
`timescale 1ns/1ps

module imm_operand (
   input  logic        clk,
   input  logic        i_load,
   input  logic        i_run,
   input  logic [11:0] i_instr_imm,
   output logic        o_imm_bit
);

   logic [11:0] imm_q;

   // LSB first, sign bit refills the top
   always_ff @(posedge clk) begin
      if (i_load) begin
         imm_q <= i_instr_imm;
      end else if (i_run) begin
         imm_q <= {imm_q[11], imm_q[11:1]};
      end
   end

   // Bits 12 to 31 come out as the sign
   assign o_imm_bit = imm_q[0];

endmodule

/* source/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
   import rv_isa_pkg::*;
   import core_ctrl_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst_n,
   input  instr_t  i_ibus_rdt,
   input  logic    i_ibus_ack,
   output decode_t o_dec
);

   // Latched instruction fields
   opcode_t     opcode;
   funct3_t     funct3;
   logic        imm30;
   reg_addr_t   rs1;
   reg_addr_t   rs2;
   reg_addr_t   rd;
   logic [11:0] imm;

   logic is_op;
   logic is_op_imm;
   logic f3_add;
   logic f3_cmp;
   logic f3_bool;
   logic f3_shift;

   // Opcode and funct3 are control, cleared so nothing writes after reset
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         opcode <= '0;
         funct3 <= '0;
      end else if (i_ibus_ack) begin
         opcode <= i_ibus_rdt[6:2];
         funct3 <= i_ibus_rdt[14:12];
      end
   end

   // Operand fields
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         imm30 <= i_ibus_rdt[30];
         rs1   <= i_ibus_rdt[19:15];
         rs2   <= i_ibus_rdt[24:20];
         rd    <= i_ibus_rdt[11:7];
         imm   <= i_ibus_rdt[31:20];
      end
   end

   assign is_op     = (opcode == OPC_OP);
   assign is_op_imm = (opcode == OPC_OP_IMM);

   // funct3 classes
   assign f3_add   = (funct3 == F3_ADD);
   assign f3_cmp   = (funct3 == F3_SLT) | (funct3 == F3_SLTU);
   assign f3_bool  = (funct3 == F3_XOR) | (funct3 == F3_OR) | (funct3 == F3_AND);
   assign f3_shift = (funct3 == F3_SLL) | (funct3 == F3_SRL);

   assign o_dec.rs1      = rs1;
   assign o_dec.rs2      = rs2;
   assign o_dec.rd       = rd;
   assign o_dec.imm      = imm;
   assign o_dec.op_b_imm = is_op_imm;
   // Shifts and other opcodes retire silently
   assign o_dec.rd_op    = (is_op | is_op_imm) & ~f3_shift;

   // Compares subtract, SUB only on OP with bit 30
   assign o_dec.alu.sub     = f3_cmp | (is_op & imm30 & f3_add);
   assign o_dec.alu.bool_op = funct3[1:0];
   // SLT 010 signed, SLTU 011 unsigned
   assign o_dec.alu.cmp_sig = ~funct3[0];
   assign o_dec.alu.rd_sel  = {f3_bool, f3_cmp, f3_add};

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file
   import rv_isa_pkg::*;
(
   input  logic      clk,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   output word_t     o_rs1,
   output word_t     o_rs2,
   input  logic      i_wen,
   input  reg_addr_t i_rd_addr,
   input  word_t     i_rd_data
);

   word_t regs [32];

   always_ff @(posedge clk) begin
      if (i_wen) begin
         regs[i_rd_addr] <= i_rd_data;
      end
   end

   // x0 reads zero whatever the array holds
   assign o_rs1 = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
   assign o_rs2 = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

   // Raw instruction word as fetched
   typedef logic [31:0] instr_t;
   // Register value, XLEN 32
   typedef logic [31:0] word_t;
   // Register index, x0 to x31
   typedef logic [4:0]  reg_addr_t;
   // Opcode without the fixed 2'b11 low bits
   typedef logic [4:0]  opcode_t;
   typedef logic [2:0]  funct3_t;

   // Supported major opcodes, bits 6 to 2
   localparam opcode_t OPC_OP     = 5'b01100;
   localparam opcode_t OPC_OP_IMM = 5'b00100;

   // funct3 codes shared by OP and OP-IMM
   localparam funct3_t F3_ADD  = 3'b000;
   localparam funct3_t F3_SLL  = 3'b001;
   localparam funct3_t F3_SLT  = 3'b010;
   localparam funct3_t F3_SLTU = 3'b011;
   localparam funct3_t F3_XOR  = 3'b100;
   localparam funct3_t F3_SRL  = 3'b101;
   localparam funct3_t F3_OR   = 3'b110;
   localparam funct3_t F3_AND  = 3'b111;

endpackage

/* source/serial_alu.sv */
`timescale 1ns/1ps

module serial_alu
   import rv_isa_pkg::*;
   import core_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      i_load,
   input  logic      i_run,
   input  logic      i_last,
   input  alu_ctrl_t i_ctrl,
   input  logic      i_op_b_imm,
   input  word_t     i_rs1,
   input  word_t     i_rs2,
   input  logic      i_imm_bit,
   output word_t     o_result
);

   // Operand and result shift registers
   word_t op_a;
   word_t op_b;
   word_t res_q;
   logic  carry;
   logic  lt_q;

   logic a_bit;
   logic b_bit;
   logic b_add;
   logic sum_bit;
   logic c_out;
   logic bool_bit;
   logic res_bit;
   logic lt_bit;

   assign a_bit = op_a[0];
   assign b_bit = i_op_b_imm ? i_imm_bit : op_b[0];

   // Subtract as a + ~b + 1, carry-in preset on load
   assign b_add   = b_bit ^ i_ctrl.sub;
   assign sum_bit = a_bit ^ b_add ^ carry;
   assign c_out   = (a_bit & b_add) | (a_bit & carry) | (b_add & carry);

   // 00 xor, 10 or, 11 and
   assign bool_bit = i_ctrl.bool_op[1] ?
                     (i_ctrl.bool_op[0] ? (a_bit & b_bit) : (a_bit | b_bit)) :
                     (a_bit ^ b_bit);

   // One-hot select between adder and bool
   assign res_bit = (i_ctrl.rd_sel[0] & sum_bit) | (i_ctrl.rd_sel[2] & bool_bit);

   // Only meaningful on the MSB
   // Signed is sign xor overflow, overflow from carry in vs carry out
   assign lt_bit = i_ctrl.cmp_sig ? (sum_bit ^ (carry ^ c_out)) : ~c_out;

   always_ff @(posedge clk) begin
      if (i_load) begin
         op_a  <= i_rs1;
         op_b  <= i_rs2;
         carry <= i_ctrl.sub;
      end else if (i_run) begin
         op_a  <= {1'b0, op_a[31:1]};
         op_b  <= {1'b0, op_b[31:1]};
         carry <= c_out;
         // Fills from the top, LSB ends up at bit 0
         res_q <= {res_bit, res_q[31:1]};
         if (i_last) begin
            lt_q <= lt_bit;
         end
      end
   end

   // Compare result is the flag zero-extended
   assign o_result = i_ctrl.rd_sel[1] ? word_t'(lt_q) : res_q;

endmodule

/* source/serial_core.sv */
`timescale 1ns/1ps

module serial_core
   import rv_isa_pkg::*;
   import core_ctrl_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   output logic      o_ibus_cyc,
   input  logic      i_ibus_ack,
   input  instr_t    i_ibus_rdt,
   output logic      o_retire,
   output logic      o_rd_wen,
   output reg_addr_t o_rd_addr,
   output word_t     o_rd_data
);

   decode_t dec;
   logic    load;
   logic    run;
   logic    last;
   logic    imm_bit;
   word_t   rs1_data;
   word_t   rs2_data;

   // Same enable the register file sees
   assign o_rd_wen  = o_retire & dec.rd_op & (dec.rd != '0);
   assign o_rd_addr = dec.rd;

   instr_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dec      (dec)
   );

   core_fsm u_fsm (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_last     (last),
      .o_ibus_cyc (o_ibus_cyc),
      .o_load     (load),
      .o_run      (run),
      .o_retire   (o_retire)
   );

   bit_counter u_cnt (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_run   (run),
      .o_last  (last)
   );

   imm_operand u_imm (
      .clk         (clk),
      .i_load      (load),
      .i_run       (run),
      .i_instr_imm (dec.imm),
      .o_imm_bit   (imm_bit)
   );

   serial_alu u_alu (
      .clk        (clk),
      .i_load     (load),
      .i_run      (run),
      .i_last     (last),
      .i_ctrl     (dec.alu),
      .i_op_b_imm (dec.op_b_imm),
      .i_rs1      (rs1_data),
      .i_rs2      (rs2_data),
      .i_imm_bit  (imm_bit),
      .o_result   (o_rd_data)
   );

   reg_file u_rf (
      .clk        (clk),
      .i_rs1_addr (dec.rs1),
      .i_rs2_addr (dec.rs2),
      .o_rs1      (rs1_data),
      .o_rs2      (rs2_data),
      .i_wen      (o_rd_wen),
      .i_rd_addr  (dec.rd),
      .i_rd_data  (o_rd_data)
   );

endmodule
